// ==== common/dtu_consts.svh ====
`ifndef DTU_CONSTS_SVH
`define DTU_CONSTS_SVH

////////////////////
// Beat and line geometry.
////////////////////
`define DTU_BEAT_W      32
`define DTU_LINE_BEATS  4
`define DTU_LINE_W      (`DTU_BEAT_W * `DTU_LINE_BEATS)
`define DTU_BURST_LEN   2   // Beats per controller command.

////////////////////
// Address and count widths.
////////////////////
`define DTU_MEM_ADDR_W  24  // Memory is addressed in beats.
`define DTU_RAM_ADDR_W  8   // Buffer is addressed in lines.
`define DTU_SIZE_W      8
`define DTU_AXI_ADDR_W  4

`define DTU_FIFO_DEPTH  16
`define DTU_RAM_LAT     2

`endif

// ==== common/dtu_pkg.sv ====
`include "dtu_consts.svh"

package dtu_pkg;

	// Buffer to memory is a write, memory to buffer is a read.
	typedef enum logic
	{
		DIR_WRITE = 1'b0,
		DIR_READ  = 1'b1
	} dtu_dir_e;

	typedef logic [$clog2(`DTU_BURST_LEN + 1)-1:0] dtu_bsize_t;

	// One transfer as set up by the host.
	typedef struct packed
	{
		dtu_dir_e                   dir;
		logic [`DTU_MEM_ADDR_W-1:0] mem_addr;
		logic [`DTU_RAM_ADDR_W-1:0] ram_addr;
		logic [`DTU_SIZE_W-1:0]     size;    // Number of lines.
	} dtu_req_t;

	// One command to the memory controller.
	typedef struct packed
	{
		logic                       write;
		logic                       read;
		logic [`DTU_MEM_ADDR_W-1:0] addr;
		dtu_bsize_t                 burst_size;
	} dtu_mem_cmd_t;

	typedef struct packed
	{
		logic busy;
		logic done;
	} dtu_status_t;

endpackage

// ==== hw/dtu_regs.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_regs
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic [`DTU_AXI_ADDR_W-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`DTU_AXI_ADDR_W-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	output logic                       start,
	output dtu_pkg::dtu_req_t          req,
	input  logic                       seq_busy,
	input  logic                       wfifo_empty,
	input  logic                       rd_drained
);
	import dtu_pkg::*;

	localparam int AXI_ADDR_W = `DTU_AXI_ADDR_W;
	localparam logic [1:0] REG_MEM_ADDR = 2'd0;
	localparam logic [1:0] REG_RAM_ADDR = 2'd1;
	localparam logic [1:0] REG_SIZE     = 2'd2;
	localparam logic [1:0] REG_CTRL     = 2'd3;
	localparam logic [1:0] RESP_OKAY    = 2'b00;
	localparam logic [1:0] RESP_SLVERR  = 2'b10;

	dtu_status_t status;
	logic [1:0]  wr_sel;
	logic [31:0] cur_wr;
	logic [31:0] wr_value;
	logic        wr_accept;
	logic        rd_accept;
	logic        start_wr;
	logic        start_rd;
	logic        start_bad;

	function automatic logic [31:0] reg_read(logic [1:0] sel, dtu_req_t r, dtu_status_t s);
		logic [31:0] v;
		v = '0;
		case (sel)
			REG_MEM_ADDR: v[`DTU_MEM_ADDR_W-1:0] = r.mem_addr;
			REG_RAM_ADDR: v[`DTU_RAM_ADDR_W-1:0] = r.ram_addr;
			REG_SIZE:     v[`DTU_SIZE_W-1:0] = r.size;
			default:      v[1:0] = {s.done, s.busy};
		endcase
		return v;
	endfunction

	assign wr_sel    = awaddr[AXI_ADDR_W-1:2];
	assign wr_accept = awready && awvalid && wvalid;
	assign rd_accept = arready && arvalid;
	assign wready    = awready;
	assign rresp     = RESP_OKAY;   // Reads never fail.

	// Unstrobed bytes keep their old value. Control bits act only when written.
	always_comb
	begin
		cur_wr = (wr_sel == REG_CTRL) ? '0 : reg_read(wr_sel, req, status);
		for (int i = 0; i < 4; i++)
			wr_value[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : cur_wr[8*i +: 8];
	end

	assign start_wr  = wr_accept && (wr_sel == REG_CTRL) && wr_value[0];
	assign start_rd  = wr_accept && (wr_sel == REG_CTRL) && wr_value[1];
	assign start_bad = (start_wr || start_rd) && (status.busy || (start_wr && start_rd));

	////////////////////
	// Handshakes and status.
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			awready <= 1'b0;
			arready <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
			start   <= 1'b0;
			status  <= '0;
		end
		else
		begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			arready <= arvalid && !arready && !rvalid;
			start   <= 1'b0;
			if (wr_accept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_accept)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if ((start_wr || start_rd) && !start_bad)
			begin
				start       <= 1'b1;
				status.busy <= 1'b1;
				status.done <= 1'b0;
			end
			else if (status.busy && !start && !seq_busy && wfifo_empty && rd_drained)
			begin
				status.busy <= 1'b0;   // Everything has left the unit.
				status.done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_accept)
		begin
			case (wr_sel)
				REG_MEM_ADDR: req.mem_addr <= wr_value[`DTU_MEM_ADDR_W-1:0];
				REG_RAM_ADDR: req.ram_addr <= wr_value[`DTU_RAM_ADDR_W-1:0];
				REG_SIZE:     req.size <= wr_value[`DTU_SIZE_W-1:0];
				default:
					if (!start_bad && (start_wr || start_rd))
						req.dir <= start_rd ? DIR_READ : DIR_WRITE;
			endcase
			bresp <= start_bad ? RESP_SLVERR : RESP_OKAY;
		end
		if (rd_accept)
			rdata <= reg_read(araddr[AXI_ADDR_W-1:2], req, status);
	end

endmodule

// ==== dtu/dtu_burst_seq.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_burst_seq
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       start,
	input  dtu_pkg::dtu_req_t          req,
	output logic                       seq_busy,
	output logic [`DTU_RAM_ADDR_W-1:0] ram_read_addr,
	input  logic [`DTU_LINE_W-1:0]     ram_read_data,
	output dtu_pkg::dtu_mem_cmd_t      mem_cmd,
	output logic                       mem_cmd_valid,
	input  logic                       mem_cmd_ready,
	output logic [`DTU_BEAT_W-1:0]     mem_wdata,
	input  logic                       mem_wdata_req,
	output logic                       wfifo_empty,
	output logic                       line_issue,
	output logic [`DTU_RAM_ADDR_W-1:0] line_ram_addr,
	input  logic                       line_room
);
	import dtu_pkg::*;

	localparam int DEPTH      = `DTU_FIFO_DEPTH;
	localparam int PTR_W      = $clog2(DEPTH);
	localparam int CNT_W      = PTR_W + 1;
	localparam int NEED_W     = CNT_W + 1;
	localparam int BEAT_W     = `DTU_BEAT_W;
	localparam int LINE_W     = `DTU_LINE_W;
	localparam int LINE_BEATS = `DTU_LINE_BEATS;
	localparam int RAM_LAT    = `DTU_RAM_LAT;
	localparam int LINE_CMDS  = `DTU_LINE_BEATS / `DTU_BURST_LEN;
	localparam dtu_bsize_t BURST_SIZE = `DTU_BURST_LEN;
	localparam logic [`DTU_MEM_ADDR_W-1:0] BURST_STEP = `DTU_BURST_LEN;
	localparam logic [`DTU_MEM_ADDR_W-1:0] LINE_STEP  = `DTU_LINE_BEATS;

	typedef enum logic {S_IDLE, S_RUN} state_e;

	state_e                     state;
	dtu_dir_e                   dir;
	logic [`DTU_MEM_ADDR_W-1:0] mem_addr;
	logic [`DTU_RAM_ADDR_W-1:0] ram_addr;
	logic [`DTU_SIZE_W-1:0]     lines_left;
	logic                       issue;
	logic [RAM_LAT-1:0]         rd_vld;
	logic [`DTU_MEM_ADDR_W-1:0] addr_pipe [RAM_LAT];
	logic [NEED_W-1:0]          pipe_lines;
	logic [NEED_W-1:0]          cmd_need;
	logic [NEED_W-1:0]          wf_need;

	dtu_mem_cmd_t               cmd_mem [DEPTH];
	dtu_mem_cmd_t               cmd_lo;
	dtu_mem_cmd_t               cmd_hi;
	logic [PTR_W-1:0]           cmd_wr;
	logic [PTR_W-1:0]           cmd_rd;
	logic [CNT_W-1:0]           cmd_count;
	logic                       cmd_push;
	logic                       cmd_pop;

	logic [BEAT_W-1:0]          wf_mem [DEPTH];
	logic [PTR_W-1:0]           wf_wr;
	logic [PTR_W-1:0]           wf_rd;
	logic [CNT_W-1:0]           wf_count;
	logic                       wf_push;
	logic                       wf_pop;

	// Room is reserved for the new line and for every line still in the RAM pipeline.
	always_comb
	begin
		pipe_lines = '0;
		for (int i = 0; i < RAM_LAT; i++)
			pipe_lines = pipe_lines + NEED_W'(rd_vld[i]);
		cmd_need = NEED_W'(cmd_count) + NEED_W'(LINE_CMDS) * (pipe_lines + 1'b1);
		wf_need  = NEED_W'(wf_count) + NEED_W'(LINE_BEATS) * (pipe_lines + 1'b1);
	end

	assign issue = (state == S_RUN) && (cmd_need <= NEED_W'(DEPTH)) &&
		(wf_need <= NEED_W'(DEPTH)) && line_room;
	assign line_issue    = issue && (dir == DIR_READ);
	assign line_ram_addr = ram_addr;
	assign ram_read_addr = ram_addr;
	assign seq_busy      = (state != S_IDLE) || (rd_vld != '0) || mem_cmd_valid;

	////////////////////
	// Line FSM.
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state  <= S_IDLE;
			rd_vld <= '0;
		end
		else
		begin
			rd_vld <= (rd_vld << 1) | RAM_LAT'(issue && (dir == DIR_WRITE));
			case (state)
				S_IDLE:
					if (start && (req.size != '0))
						state <= S_RUN;
				S_RUN:
					if (issue && (lines_left == `DTU_SIZE_W'(1)))
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == S_IDLE) && start)
		begin
			dir        <= req.dir;
			mem_addr   <= req.mem_addr;
			ram_addr   <= req.ram_addr;
			lines_left <= req.size;
		end
		else if (issue)
		begin
			mem_addr   <= mem_addr + LINE_STEP;
			ram_addr   <= ram_addr + 1'b1;
			lines_left <= lines_left - 1'b1;
		end
		for (int i = RAM_LAT - 1; i > 0; i--)
			addr_pipe[i] <= addr_pipe[i-1];
		addr_pipe[0] <= mem_addr;   // Follows the buffer read.
	end

	////////////////////
	// Command FIFO.
	////////////////////
	// Write commands wait for their data so the controller never pulls an empty FIFO.
	assign cmd_push = wf_push || line_issue;

	always_comb
	begin
		cmd_lo.write      = (dir == DIR_WRITE);
		cmd_lo.read       = (dir == DIR_READ);
		cmd_lo.addr       = (dir == DIR_READ) ? mem_addr : addr_pipe[RAM_LAT-1];
		cmd_lo.burst_size = BURST_SIZE;
		cmd_hi            = cmd_lo;
		cmd_hi.addr       = cmd_lo.addr + BURST_STEP;
	end

	assign mem_cmd_valid = (cmd_count != '0);
	assign mem_cmd       = cmd_mem[cmd_rd];
	assign cmd_pop       = mem_cmd_valid && mem_cmd_ready;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			cmd_wr    <= '0;
			cmd_rd    <= '0;
			cmd_count <= '0;
			wf_wr     <= '0;
			wf_rd     <= '0;
			wf_count  <= '0;
		end
		else
		begin
			if (cmd_push)
				cmd_wr <= cmd_wr + PTR_W'(2);
			if (cmd_pop)
				cmd_rd <= cmd_rd + 1'b1;
			cmd_count <= cmd_count + (cmd_push ? CNT_W'(2) : '0) - CNT_W'(cmd_pop);
			if (wf_push)
				wf_wr <= wf_wr + PTR_W'(LINE_BEATS);
			if (wf_pop)
				wf_rd <= wf_rd + 1'b1;
			wf_count <= wf_count + (wf_push ? CNT_W'(LINE_BEATS) : '0) - CNT_W'(wf_pop);
		end
	end

	////////////////////
	// Write-data FIFO.
	////////////////////
	assign wf_push     = rd_vld[RAM_LAT-1];
	assign wf_pop      = mem_wdata_req && (wf_count != '0);
	assign mem_wdata   = wf_mem[wf_rd];
	assign wfifo_empty = (wf_count == '0);

	always_ff @(posedge clk)
	begin
		if (cmd_push)
		begin
			cmd_mem[cmd_wr]        <= cmd_lo;
			cmd_mem[cmd_wr + 1'b1] <= cmd_hi;
		end
		if (wf_push)
			for (int k = 0; k < LINE_BEATS; k++)
				wf_mem[wf_wr + PTR_W'(k)] <= ram_read_data[LINE_W - 1 - k*BEAT_W -: BEAT_W];
	end

endmodule

// ==== dtu/dtu_return_path.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_return_path
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       line_issue,
	input  logic [`DTU_RAM_ADDR_W-1:0] line_ram_addr,
	output logic                       line_room,
	input  logic [`DTU_BEAT_W-1:0]     mem_rdata,
	input  logic                       mem_rdata_valid,
	output logic                       ram_write_en,
	output logic [`DTU_RAM_ADDR_W-1:0] ram_write_addr,
	output logic [`DTU_LINE_W-1:0]     ram_write_data,
	output logic                       rd_drained
);
	localparam int DEPTH  = `DTU_FIFO_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int CNT_W  = PTR_W + 1;
	localparam int BEAT_W = `DTU_BEAT_W;
	localparam int LINE_W = `DTU_LINE_W;
	localparam int BCNT_W = $clog2(`DTU_LINE_BEATS);
	localparam logic [BCNT_W-1:0] LAST_BEAT = BCNT_W'(`DTU_LINE_BEATS - 1);

	logic [`DTU_RAM_ADDR_W-1:0] aq_mem [DEPTH];
	logic [PTR_W-1:0]           aq_wr;
	logic [PTR_W-1:0]           aq_rd;
	logic [CNT_W-1:0]           aq_count;
	logic [BCNT_W-1:0]          beat_cnt;
	logic [LINE_W-BEAT_W-1:0]   line_buf;   // The beats before the last one.
	logic                       line_done;

	assign line_done  = mem_rdata_valid && (beat_cnt == LAST_BEAT);
	assign line_room  = (aq_count != CNT_W'(DEPTH));

	// A line still being written counts as in flight.
	assign rd_drained = (aq_count == '0) && (beat_cnt == '0) && !ram_write_en;

	////////////////////
	// Address queue and beat count.
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			aq_wr        <= '0;
			aq_rd        <= '0;
			aq_count     <= '0;
			beat_cnt     <= '0;
			ram_write_en <= 1'b0;
		end
		else
		begin
			if (line_issue)
				aq_wr <= aq_wr + 1'b1;
			if (line_done)
				aq_rd <= aq_rd + 1'b1;
			aq_count <= aq_count + CNT_W'(line_issue) - CNT_W'(line_done);
			if (mem_rdata_valid)
				beat_cnt <= beat_cnt + 1'b1;   // Wraps at the end of a line.
			ram_write_en <= line_done;
		end
	end

	////////////////////
	// Line assembly.
	////////////////////
	// Beats come most significant first, so each new beat shifts in at the bottom.
	always_ff @(posedge clk)
	begin
		if (line_issue)
			aq_mem[aq_wr] <= line_ram_addr;
		if (mem_rdata_valid)
			line_buf <= {line_buf[LINE_W-2*BEAT_W-1:0], mem_rdata};
		if (line_done)
		begin
			ram_write_data <= {line_buf, mem_rdata};
			ram_write_addr <= aq_mem[aq_rd];
		end
	end

endmodule

// ==== hw/dtu_top.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_top
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic [`DTU_AXI_ADDR_W-1:0] awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`DTU_AXI_ADDR_W-1:0] araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	output logic [`DTU_RAM_ADDR_W-1:0] ram_read_addr,
	input  logic [`DTU_LINE_W-1:0]     ram_read_data,
	output logic                       ram_write_en,
	output logic [`DTU_RAM_ADDR_W-1:0] ram_write_addr,
	output logic [`DTU_LINE_W-1:0]     ram_write_data,
	output dtu_pkg::dtu_mem_cmd_t      mem_cmd,
	output logic                       mem_cmd_valid,
	input  logic                       mem_cmd_ready,
	output logic [`DTU_BEAT_W-1:0]     mem_wdata,
	input  logic                       mem_wdata_req,
	input  logic [`DTU_BEAT_W-1:0]     mem_rdata,
	input  logic                       mem_rdata_valid
);
	import dtu_pkg::*;

	dtu_req_t                   req;
	logic                       start;
	logic                       seq_busy;
	logic                       wfifo_empty;
	logic                       rd_drained;
	logic                       line_issue;
	logic [`DTU_RAM_ADDR_W-1:0] line_ram_addr;
	logic                       line_room;

	dtu_regs dtu_regs_i
	(
		.clk         (clk),
		.reset_n     (reset_n),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.start       (start),
		.req         (req),
		.seq_busy    (seq_busy),
		.wfifo_empty (wfifo_empty),
		.rd_drained  (rd_drained)
	);

	dtu_burst_seq dtu_burst_seq_i
	(
		.clk           (clk),
		.reset_n       (reset_n),
		.start         (start),
		.req           (req),
		.seq_busy      (seq_busy),
		.ram_read_addr (ram_read_addr),
		.ram_read_data (ram_read_data),
		.mem_cmd       (mem_cmd),
		.mem_cmd_valid (mem_cmd_valid),
		.mem_cmd_ready (mem_cmd_ready),
		.mem_wdata     (mem_wdata),
		.mem_wdata_req (mem_wdata_req),
		.wfifo_empty   (wfifo_empty),
		.line_issue    (line_issue),
		.line_ram_addr (line_ram_addr),
		.line_room     (line_room)
	);

	dtu_return_path dtu_return_path_i
	(
		.clk             (clk),
		.reset_n         (reset_n),
		.line_issue      (line_issue),
		.line_ram_addr   (line_ram_addr),
		.line_room       (line_room),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid),
		.ram_write_en    (ram_write_en),
		.ram_write_addr  (ram_write_addr),
		.ram_write_data  (ram_write_data),
		.rd_drained      (rd_drained)
	);

endmodule

// ==== tests/dtu_ext_models.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_ext_models
(
	input  logic                       clk,
	input  logic                       stall_en,
	input  logic [`DTU_RAM_ADDR_W-1:0] ram_read_addr,
	output logic [`DTU_LINE_W-1:0]     ram_read_data,
	input  logic                       ram_write_en,
	input  logic [`DTU_RAM_ADDR_W-1:0] ram_write_addr,
	input  logic [`DTU_LINE_W-1:0]     ram_write_data,
	input  dtu_pkg::dtu_mem_cmd_t      mem_cmd,
	input  logic                       mem_cmd_valid,
	output logic                       mem_cmd_ready,
	input  logic [`DTU_BEAT_W-1:0]     mem_wdata,
	output logic                       mem_wdata_req,
	output logic [`DTU_BEAT_W-1:0]     mem_rdata,
	output logic                       mem_rdata_valid
);
	import dtu_pkg::*;

	logic [`DTU_LINE_W-1:0] line_ram [256];
	logic [`DTU_BEAT_W-1:0] beat_mem [1024];   // Low address bits of the memory only.
	logic [`DTU_LINE_W-1:0] rd_stage;
	logic [`DTU_LINE_W-1:0] rd_data;
	logic                   q_write [$];
	logic [9:0]             q_addr [$];
	int                     beat_idx;
	logic [7:0]             lfsr;

	function automatic logic [7:0] lfsr_step(logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	initial
	begin
		lfsr            = 8'd85;
		beat_idx        = 0;
		mem_cmd_ready   = 1'b0;
		mem_wdata_req   = 1'b0;
		mem_rdata_valid = 1'b0;
		mem_rdata       = '0;
		ram_read_data   = '0;
	end

	// Controller outputs change on the falling edge only.
	always @(negedge clk)
	begin
		logic stall_cmd;
		logic stall_beat;
		stall_cmd  = 1'b0;
		stall_beat = 1'b0;
		if (stall_en)
		begin
			lfsr       = lfsr_step(lfsr);
			stall_cmd  = lfsr[0];
			lfsr       = lfsr_step(lfsr);
			stall_beat = lfsr[0];
		end
		ram_read_data   = rd_data;
		mem_cmd_ready   = !stall_cmd;
		mem_wdata_req   = 1'b0;
		mem_rdata_valid = 1'b0;
		if (q_addr.size() != 0)
		begin
			if (q_write[0])
				mem_wdata_req = !stall_beat;
			else
			begin
				mem_rdata_valid = !stall_beat;
				mem_rdata       = beat_mem[q_addr[0] + 10'(beat_idx)];
			end
		end
	end

	always @(posedge clk)
	begin
		if (mem_wdata_req)
			beat_mem[q_addr[0] + 10'(beat_idx)] = mem_wdata;
		if (mem_wdata_req || mem_rdata_valid)
		begin
			beat_idx = beat_idx + 1;
			if (beat_idx == `DTU_BURST_LEN)
			begin
				beat_idx = 0;
				void'(q_write.pop_front());
				void'(q_addr.pop_front());
			end
		end
		if (mem_cmd_valid && mem_cmd_ready)
		begin
			q_write.push_back(mem_cmd.write);
			q_addr.push_back(mem_cmd.addr[9:0]);
		end
		if (ram_write_en)
			line_ram[ram_write_addr] = ram_write_data;
		rd_stage <= line_ram[ram_read_addr];   // Two register stages.
		rd_data  <= rd_stage;
	end

endmodule

// ==== tests/dtu_tb.sv ====
`timescale 1ns/100ps
`include "dtu_consts.svh"

module dtu_tb;
	import dtu_pkg::*;

	typedef struct packed
	{
		dtu_dir_e                   dir;
		logic [`DTU_MEM_ADDR_W-1:0] mem_addr;
		logic [`DTU_RAM_ADDR_W-1:0] ram_addr;
		logic [`DTU_SIZE_W-1:0]     size;
		logic                       stall;
		logic                       expect_slverr;
	} row_t;

	localparam int N_ROWS = 7;

	logic clk = 1'b0;
	logic reset_n, awvalid, wvalid, bready, arvalid, rready, stall_en;
	logic awready, wready, bvalid, arready, rvalid;
	logic [3:0] awaddr, araddr, wstrb;
	logic [31:0] wdata, rdata;
	logic [1:0] bresp, rresp;
	logic [`DTU_RAM_ADDR_W-1:0] ram_read_addr, ram_write_addr;
	logic [`DTU_LINE_W-1:0] ram_read_data, ram_write_data;
	logic ram_write_en, mem_cmd_valid, mem_cmd_ready, mem_wdata_req, mem_rdata_valid;
	logic [`DTU_BEAT_W-1:0] mem_wdata, mem_rdata;
	dtu_mem_cmd_t mem_cmd;

	row_t rows [N_ROWS];
	logic [`DTU_LINE_W-1:0] ref_line [256];
	logic [`DTU_BEAT_W-1:0] ref_beat [1024];
	logic [`DTU_MEM_ADDR_W-1:0] exp_cmds [$];
	logic exp_write;
	int cycles = 0;
	int limit = 1000;
	int ram_writes = 0;

	always #50 clk = ~clk;

	dtu_top dtu_top_i (.*);

	dtu_ext_models dtu_ext_models_i
	(
		.clk (clk), .stall_en (stall_en),
		.ram_read_addr (ram_read_addr), .ram_read_data (ram_read_data),
		.ram_write_en (ram_write_en), .ram_write_addr (ram_write_addr),
		.ram_write_data (ram_write_data), .mem_cmd (mem_cmd),
		.mem_cmd_valid (mem_cmd_valid), .mem_cmd_ready (mem_cmd_ready),
		.mem_wdata (mem_wdata), .mem_wdata_req (mem_wdata_req),
		.mem_rdata (mem_rdata), .mem_rdata_valid (mem_rdata_valid)
	);

	task automatic compare(input logic [127:0] actual, input logic [127:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "Stopped at first error.");
		end
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(negedge clk); while (!awready);
		compare(wready, 1'b1, "wready with awready");
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		compare(bvalid, 1'b1, "bvalid after write");
		resp    = bresp;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		compare(rvalid, 1'b1, "rvalid after read");
		data    = rdata;
		resp    = rresp;
	endtask

	////////////////////
	// Monitors.
	////////////////////
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", limit);
			$display(">>> FAIL");
			$fatal(1, "Timeout.");
		end
	end

	always @(posedge clk)
	begin
		if (ram_write_en === 1'b1)
			ram_writes++;
		if (mem_cmd_valid === 1'b1 && mem_cmd_ready)
		begin
			compare(exp_cmds.size() != 0, 1, "command count");
			compare(mem_cmd.addr, exp_cmds.pop_front(), "command address");
			compare(mem_cmd.burst_size, `DTU_BURST_LEN, "burst size");
			compare({mem_cmd.write, mem_cmd.read}, {exp_write, !exp_write}, "command kind");
		end
	end

	task automatic run_row(input row_t r);
		logic [31:0] data;
		logic [1:0]  resp;
		logic [`DTU_MEM_ADDR_W-1:0] ma;
		ram_writes = 0;
		stall_en   = r.stall;
		axi_write(4'h0, 32'(r.mem_addr), resp);
		compare(resp, 2'b00, "write mem_addr resp");
		axi_write(4'h4, 32'(r.ram_addr), resp);
		compare(resp, 2'b00, "write ram_addr resp");
		axi_write(4'h8, 32'(r.size), resp);
		compare(resp, 2'b00, "write size resp");
		axi_read(4'h0, data, resp);
		compare({resp, data}, {2'b00, 32'(r.mem_addr)}, "mem_addr readback");
		axi_read(4'h4, data, resp);
		compare({resp, data}, {2'b00, 32'(r.ram_addr)}, "ram_addr readback");
		axi_read(4'h8, data, resp);
		compare({resp, data}, {2'b00, 32'(r.size)}, "size readback");
		axi_read(4'hC, data, resp);
		compare(data[0], 1'b0, "busy before start");
		exp_write = (r.dir == DIR_WRITE);
		for (int i = 0; i < 2 * r.size; i++)
			exp_cmds.push_back(r.mem_addr + `DTU_MEM_ADDR_W'(2 * i));
		axi_write(4'hC, (r.dir == DIR_READ) ? 32'd2 : 32'd1, resp);
		compare(resp, 2'b00, "start resp");
		if (r.expect_slverr)
		begin
			// The opposite direction must be refused while busy.
			axi_write(4'hC, (r.dir == DIR_READ) ? 32'd1 : 32'd2, resp);
			compare(resp, 2'b10, "start while busy resp");
		end
		do axi_read(4'hC, data, resp); while (!data[1]);
		compare(data[1:0], 2'b10, "status after done");
		compare(exp_cmds.size(), 0, "commands left");
		compare(ram_writes, (r.dir == DIR_READ) ? r.size : 0, "buffer write count");
		for (int i = 0; i < r.size; i++)
		begin
			ma = r.mem_addr + `DTU_MEM_ADDR_W'(4 * i);
			for (int k = 0; k < `DTU_LINE_BEATS; k++)
				if (r.dir == DIR_WRITE)
					ref_beat[10'(ma + k)] = ref_line[8'(r.ram_addr + i)][127 - 32*k -: 32];
				else
					ref_line[8'(r.ram_addr + i)][127 - 32*k -: 32] = ref_beat[10'(ma + k)];
		end
		for (int a = 0; a < 1024; a++)
			compare(dtu_ext_models_i.beat_mem[a], ref_beat[a], $sformatf("memory beat %0d", a));
		for (int a = 0; a < 256; a++)
			compare(dtu_ext_models_i.line_ram[a], ref_line[a], $sformatf("buffer line %0d", a));
	endtask

	initial
	begin
		reset_n = 1'b0;
		{awvalid, wvalid, arvalid, stall_en} = '0;
		{bready, rready} = 2'b11;
		awaddr = '0;
		araddr = '0;
		wdata  = '0;
		wstrb  = 4'hf;
		rows[0] = '{DIR_WRITE, 24'h000, 8'h10, 8'd4, 1'b0, 1'b0};
		rows[1] = '{DIR_READ, 24'h100, 8'h40, 8'd5, 1'b0, 1'b0};
		rows[2] = '{DIR_WRITE, 24'h040, 8'h20, 8'd8, 1'b1, 1'b0};
		rows[3] = '{DIR_READ, 24'h180, 8'h60, 8'd8, 1'b1, 1'b0};
		rows[4] = '{DIR_WRITE, 24'h200, 8'h30, 8'd6, 1'b1, 1'b1};
		rows[5] = '{DIR_READ, 24'h010, 8'h80, 8'd0, 1'b0, 1'b0};   // Zero length.
		rows[6] = '{DIR_READ, 24'h000, 8'h90, 8'd20, 1'b1, 1'b1};
		for (int i = 0; i < N_ROWS; i++)
			limit += 64 * rows[i].size;
		// Fill patterns depend on every address bit.
		for (int a = 0; a < 1024; a++)
		begin
			ref_beat[a] = 32'h9e3779b9 * (a + 1) ^ 32'(a << 20);
			dtu_ext_models_i.beat_mem[a] = ref_beat[a];
		end
		for (int l = 0; l < 256; l++)
		begin
			for (int k = 0; k < 4; k++)
				ref_line[l][32*k +: 32] = 32'h5bd1e995 * (4 * l + k + 1) ^ 32'(l << 24);
			dtu_ext_models_i.line_ram[l] = ref_line[l];
		end
		repeat (3) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < N_ROWS; i++)
			run_row(rows[i]);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== dtu.f ====
+incdir+common
common/dtu_pkg.sv
hw/dtu_regs.sv
dtu/dtu_burst_seq.sv
dtu/dtu_return_path.sv
hw/dtu_top.sv
tests/dtu_ext_models.sv
tests/dtu_tb.sv

// ==== Makefile ====
# Verilator simulation of the dtu testbench.

VERILATOR ?= verilator
TOP       ?= dtu_tb
FILELIST  ?= dtu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q -- '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
